//--- rtl/cu_cfg.svh
/*
 * Control unit configuration: instruction, register file and memory
 * select widths shared by the package and the RTL
 */
`ifndef CU_CFG_SVH
`define CU_CFG_SVH

// Width of the opcode held in the instruction register
`define CU_IR_WIDTH 12

// Number of registers on the internal bus, one enable bit each
`define CU_REG_COUNT 16

// Width of the memory read select
`define CU_MEM_SEL_WIDTH 2

`endif

//--- rtl/cu_pkg.sv
/*
 * Control unit types: opcodes, instruction classes, FSM states, ALU and
 * memory select codes, the register mask and the control word
 */
`default_nettype none

`include "cu_cfg.svh"

package cu_pkg;

    // One-hot register mask, bit 0 is AC and the top bit is DR
    typedef logic [`CU_REG_COUNT-1:0] reg_mask_t;

    localparam reg_mask_t REG_NONE   = 16'h0000;
    localparam reg_mask_t REG_AC     = 16'h0001;
    localparam reg_mask_t REG_PC     = 16'h0002;
    localparam reg_mask_t REG_AR     = 16'h0004;
    localparam reg_mask_t REG_IR     = 16'h0008;
    localparam reg_mask_t REG_R      = 16'h0010;
    localparam reg_mask_t REG_ROW    = 16'h0020;
    localparam reg_mask_t REG_CAT    = 16'h0040;
    localparam reg_mask_t REG_CB     = 16'h0080;
    localparam reg_mask_t REG_RNOW   = 16'h0100;
    localparam reg_mask_t REG_CATNOW = 16'h0200;
    localparam reg_mask_t REG_CBNOW  = 16'h0400;
    localparam reg_mask_t REG_ALPHAP = 16'h0800;
    localparam reg_mask_t REG_BETAP  = 16'h1000;
    localparam reg_mask_t REG_GAMMAP = 16'h2000;
    localparam reg_mask_t REG_TOTAL  = 16'h4000;
    localparam reg_mask_t REG_DR     = 16'h8000;

    typedef enum logic [`CU_IR_WIDTH-1:0] {
        CLR = 12'd0, LOAD, MUL, ADD, SUB, INC, JUMP, JUMPZ,
        MVAC_TOTAL = 12'd8, MVAC_ALPHAP, MVAC_BETAP, MVAC_GAMMAP, MVAC_R, MVAC_ROW,
        MVAC_CAT, MVAC_CB, MVAC_RNOW, MVAC_CATNOW, MVAC_CBNOW,
        MOV_TOTAL = 12'd19, MOV_ALPHAP, MOV_BETAP, MOV_GAMMAP, MOV_R, MOV_ROW,
        MOV_CAT, MOV_CB, MOV_RNOW, MOV_CATNOW, MOV_CBNOW,
        STORE = 12'd30, LOAD_REG, ENDOP
    } opcode_e;

    // All MVAC_x share one class, as do all MOV_x
    typedef enum logic [3:0] {
        CLS_CLR, CLS_LOAD, CLS_MUL, CLS_ADD, CLS_SUB, CLS_INC, CLS_JUMP,
        CLS_JUMPZ, CLS_MVAC, CLS_MOV, CLS_STORE, CLS_LOAD_REG, CLS_END, CLS_BAD
    } instr_class_e;

    typedef struct packed {
        instr_class_e cls;
        reg_mask_t    operand;   // Target register of a move, empty otherwise
    } decoded_instr_t;

    typedef enum logic [5:0] {
        IDLE, FETCH1, FETCH2, FETCH3, FETCH4,
        CLR1, LOAD1, LOAD2, LOAD3, LOAD4, LOAD5,
        MUL1, ADD1, SUB1, INC1, JUMP1, JUMP2, MVAC1, MOV1, STORE1, STORE2,
        LOAD_REG1, LOAD_REG2, LOAD_REG3,
        JUMPZ_TAKEN1, JUMPZ_TAKEN2, JUMPZ_TAKEN3, JUMPZ_SKIP1, JUMPZ_SKIP2,
        ENDOP1
    } cu_state_e;

    typedef enum logic [2:0] {
        ALU_IDLE = 3'd0, ALU_PASS = 3'd1, ALU_ADD = 3'd2, ALU_SUB = 3'd3,
        ALU_MUL = 3'd4, ALU_INC = 3'd5, ALU_ZERO = 3'd6
    } alu_op_e;

    // Selects which memory drives DR
    typedef enum logic [`CU_MEM_SEL_WIDTH-1:0] {
        MEM_NONE = 2'd0, MEM_DATA = 2'd1, MEM_INSTR = 2'd2
    } mem_sel_e;

    typedef struct packed {
        reg_mask_t write_en;   // Bus registers loaded at the end of the cycle
        reg_mask_t read_en;    // Bus registers driving the bus
        mem_sel_e  mem_read;
        logic      mem_write;
        alu_op_e   alu_op;
        logic      pc_inc;
    } ctrl_word_t;

    localparam ctrl_word_t CTRL_INACTIVE = '{
        write_en:  REG_NONE,
        read_en:   REG_NONE,
        mem_read:  MEM_NONE,
        mem_write: 1'b0,
        alu_op:    ALU_IDLE,
        pc_inc:    1'b0
    };

endpackage

`default_nettype wire

//--- rtl/opcode_decoder.sv
/*
 * Opcode decoder: sorts the raw opcode into an instruction class and, for
 * the register moves, the one-hot mask of the register being moved
 */
`timescale 1ns/1ps
`default_nettype none

`include "cu_cfg.svh"

module opcode_decoder import cu_pkg::*;
(
    input  logic [`CU_IR_WIDTH-1:0] opcode,
    output decoded_instr_t          decoded
);

    opcode_e op;

    assign op = opcode_e'(opcode);

    always_comb
    begin
        case (op)
            CLR:      decoded.cls = CLS_CLR;
            LOAD:     decoded.cls = CLS_LOAD;
            MUL:      decoded.cls = CLS_MUL;
            ADD:      decoded.cls = CLS_ADD;
            SUB:      decoded.cls = CLS_SUB;
            INC:      decoded.cls = CLS_INC;
            JUMP:     decoded.cls = CLS_JUMP;
            JUMPZ:    decoded.cls = CLS_JUMPZ;
            MVAC_TOTAL, MVAC_ALPHAP, MVAC_BETAP, MVAC_GAMMAP, MVAC_R, MVAC_ROW,
            MVAC_CAT, MVAC_CB, MVAC_RNOW, MVAC_CATNOW, MVAC_CBNOW:
                decoded.cls = CLS_MVAC;
            MOV_TOTAL, MOV_ALPHAP, MOV_BETAP, MOV_GAMMAP, MOV_R, MOV_ROW,
            MOV_CAT, MOV_CB, MOV_RNOW, MOV_CATNOW, MOV_CBNOW:
                decoded.cls = CLS_MOV;
            STORE:    decoded.cls = CLS_STORE;
            LOAD_REG: decoded.cls = CLS_LOAD_REG;
            ENDOP:    decoded.cls = CLS_END;
            default:  decoded.cls = CLS_BAD;   // Anything above ENDOP
        endcase
    end

    // MVAC_x and MOV_x name the same register at the same offset in their group
    always_comb
    begin
        case (op)
            MVAC_TOTAL,  MOV_TOTAL:  decoded.operand = REG_TOTAL;
            MVAC_ALPHAP, MOV_ALPHAP: decoded.operand = REG_ALPHAP;
            MVAC_BETAP,  MOV_BETAP:  decoded.operand = REG_BETAP;
            MVAC_GAMMAP, MOV_GAMMAP: decoded.operand = REG_GAMMAP;
            MVAC_R,      MOV_R:      decoded.operand = REG_R;
            MVAC_ROW,    MOV_ROW:    decoded.operand = REG_ROW;
            MVAC_CAT,    MOV_CAT:    decoded.operand = REG_CAT;
            MVAC_CB,     MOV_CB:     decoded.operand = REG_CB;
            MVAC_RNOW,   MOV_RNOW:   decoded.operand = REG_RNOW;
            MVAC_CATNOW, MOV_CATNOW: decoded.operand = REG_CATNOW;
            MVAC_CBNOW,  MOV_CBNOW:  decoded.operand = REG_CBNOW;
            default:                 decoded.operand = REG_NONE;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/instr_sequencer.sv
/*
 * Instruction sequencer: steps through fetch and the execute states of the
 * decoded instruction and holds the move operand for the execute phase
 */
`timescale 1ns/1ps
`default_nettype none

module instr_sequencer import cu_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  logic           zflag,
    input  decoded_instr_t decoded,
    output cu_state_e      state,
    output reg_mask_t      operand
);

    cu_state_e state_next;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    // The opcode is stable from FETCH4, so the operand is taken as FETCH4 ends
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            operand <= REG_NONE;
        end
        else if (state == FETCH4)
        begin
            operand <= decoded.operand;
        end
    end

    always_comb
    begin
        case (state)
            IDLE:         state_next = start ? FETCH1 : IDLE;
            FETCH1:       state_next = FETCH2;
            FETCH2:       state_next = FETCH3;
            FETCH3:       state_next = FETCH4;
            FETCH4:
            begin
                // Dispatch on the class, the zero flag only matters for JUMPZ
                case (decoded.cls)
                    CLS_CLR:      state_next = CLR1;
                    CLS_LOAD:     state_next = LOAD1;
                    CLS_MUL:      state_next = MUL1;
                    CLS_ADD:      state_next = ADD1;
                    CLS_SUB:      state_next = SUB1;
                    CLS_INC:      state_next = INC1;
                    CLS_JUMP:     state_next = JUMP1;
                    CLS_JUMPZ:    state_next = zflag ? JUMPZ_TAKEN1 : JUMPZ_SKIP1;
                    CLS_MVAC:     state_next = MVAC1;
                    CLS_MOV:      state_next = MOV1;
                    CLS_STORE:    state_next = STORE1;
                    CLS_LOAD_REG: state_next = LOAD_REG1;
                    CLS_END:      state_next = ENDOP1;
                    default:      state_next = IDLE;   // Undefined opcode stops the unit
                endcase
            end
            LOAD1:        state_next = LOAD2;
            LOAD2:        state_next = LOAD3;
            LOAD3:        state_next = LOAD4;   // Wait for the data memory
            LOAD4:        state_next = LOAD5;
            JUMP1:        state_next = JUMP2;
            STORE1:       state_next = STORE2;
            LOAD_REG1:    state_next = LOAD_REG2;
            LOAD_REG2:    state_next = LOAD_REG3;
            JUMPZ_TAKEN1: state_next = JUMPZ_TAKEN2;
            JUMPZ_TAKEN2: state_next = JUMPZ_TAKEN3;
            JUMPZ_SKIP1:  state_next = JUMPZ_SKIP2;
            CLR1, LOAD5, MUL1, ADD1, SUB1, INC1, JUMP2, MVAC1, MOV1, STORE2,
            LOAD_REG3, JUMPZ_TAKEN3, JUMPZ_SKIP2:
                state_next = FETCH1;
            ENDOP1:       state_next = IDLE;
            default:      state_next = IDLE;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/control_word_gen.sv
/*
 * Control word generator: one control word per FSM state, with the move
 * operand steering the register enables in MVAC1 and MOV1
 */
`timescale 1ns/1ps
`default_nettype none

module control_word_gen import cu_pkg::*;
(
    input  cu_state_e  state,
    input  reg_mask_t  operand,
    output ctrl_word_t ctrl
);

    always_comb
    begin
        ctrl = CTRL_INACTIVE;   // Fields a state does not name stay inactive
        case (state)
            FETCH1:
            begin
                ctrl.write_en = REG_AR;   // AR <- PC
                ctrl.read_en  = REG_PC;
            end
            FETCH2:
            begin
                // DR takes the instruction word while PC moves on
                ctrl.write_en = REG_DR;
                ctrl.mem_read = MEM_INSTR;
                ctrl.pc_inc   = 1'b1;
            end
            FETCH3:
            begin
                ctrl.write_en = REG_IR | REG_AR;
                ctrl.read_en  = REG_DR | REG_PC;
            end
            CLR1:
            begin
                ctrl.write_en = REG_AC;
                ctrl.alu_op   = ALU_ZERO;
            end
            LOAD1:
            begin
                ctrl.write_en = REG_DR;   // Address word follows the opcode
                ctrl.mem_read = MEM_INSTR;
            end
            LOAD2:
            begin
                ctrl.write_en = REG_AR;
                ctrl.read_en  = REG_DR;
            end
            LOAD3:        ctrl.pc_inc = 1'b1;
            LOAD4:
            begin
                ctrl.write_en = REG_DR;
                ctrl.mem_read = MEM_DATA;
            end
            LOAD5, LOAD_REG3:
            begin
                ctrl.write_en = REG_AC;   // AC <- DR through the ALU
                ctrl.read_en  = REG_DR;
                ctrl.alu_op   = ALU_PASS;
            end
            MUL1, ADD1, SUB1:
            begin
                ctrl.write_en = REG_AC;
                ctrl.read_en  = REG_R;
                ctrl.alu_op   = (state == MUL1) ? ALU_MUL :
                                (state == ADD1) ? ALU_ADD : ALU_SUB;
            end
            INC1:
            begin
                ctrl.write_en = REG_AC;
                ctrl.alu_op   = ALU_INC;
            end
            JUMP1, JUMPZ_TAKEN1:
            begin
                // Jump target is the word after the opcode
                ctrl.write_en = REG_DR;
                ctrl.mem_read = MEM_INSTR;
                ctrl.pc_inc   = 1'b1;
            end
            JUMP2, JUMPZ_TAKEN2:
            begin
                ctrl.write_en = REG_PC;
                ctrl.read_en  = REG_DR;
            end
            JUMPZ_TAKEN3, JUMPZ_SKIP2:
            begin
                ctrl.write_en = REG_AR;
                ctrl.read_en  = REG_PC;
            end
            JUMPZ_SKIP1:  ctrl.pc_inc = 1'b1;   // Step over the unused target word
            MVAC1:
            begin
                ctrl.write_en = operand;
                ctrl.read_en  = REG_AC;
            end
            MOV1:
            begin
                ctrl.write_en = REG_AC;
                ctrl.read_en  = operand;
                ctrl.alu_op   = ALU_PASS;
            end
            STORE1:
            begin
                ctrl.write_en = REG_AR;   // GAMMAP holds the store address
                ctrl.read_en  = REG_GAMMAP;
            end
            STORE2:
            begin
                ctrl.write_en  = REG_DR;
                ctrl.read_en   = REG_AC;
                ctrl.mem_write = 1'b1;
            end
            LOAD_REG1:
            begin
                ctrl.write_en = REG_AR;
                ctrl.read_en  = REG_AC;
                ctrl.mem_read = MEM_DATA;
            end
            LOAD_REG2:
            begin
                ctrl.write_en = REG_DR;
                ctrl.mem_read = MEM_DATA;
            end
            IDLE, FETCH4, ENDOP1: ctrl = CTRL_INACTIVE;
            default:              ctrl = CTRL_INACTIVE;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/control_unit.sv
/*
 * Control unit of the accumulator processor: decoder, sequencer and
 * control word generator
 */
`timescale 1ns/1ps
`default_nettype none

`include "cu_cfg.svh"

module control_unit import cu_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    zflag,
    input  logic [`CU_IR_WIDTH-1:0] opcode,
    output ctrl_word_t              ctrl
);

    decoded_instr_t decoded;
    cu_state_e      state;
    reg_mask_t      operand;   // Move target held through the execute phase

    opcode_decoder i_opcode_decoder (
        .opcode  (opcode),
        .decoded (decoded)
    );

    instr_sequencer i_instr_sequencer (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .zflag   (zflag),
        .decoded (decoded),
        .state   (state),
        .operand (operand)
    );

    control_word_gen i_control_word_gen (
        .state   (state),
        .operand (operand),
        .ctrl    (ctrl)
    );

endmodule

`default_nettype wire

//--- sim/cu_test_table.svh
/*
 * Control unit test table: one row per instruction run, with the expected
 * fetch and execute control words built from the bus transfer rules
 */
`ifndef CU_TEST_TABLE_SVH
`define CU_TEST_TABLE_SVH

typedef struct packed {
    logic [8*16-1:0]         name;
    logic [`CU_IR_WIDTH-1:0] opcode;
    logic                    zflag;
    logic [2:0]              exec_cycles;   // Execute states after FETCH4
    logic                    next_idle;     // Unit stops in IDLE after this row
} test_row_t;

test_row_t test_table [$];

task automatic add_row(input logic [8*16-1:0] name, input logic [`CU_IR_WIDTH-1:0] op,
                       input logic z, input logic [2:0] n, input logic idle);
    test_row_t row;
    row.name        = name;
    row.opcode      = op;
    row.zflag       = z;
    row.exec_cycles = n;
    row.next_idle   = idle;
    test_table.push_back(row);
endtask

task automatic build_table();
    add_row("CLR", CLR, 1'b0, 3'd1, 1'b0);
    add_row("MUL", MUL, 1'b0, 3'd1, 1'b0);
    add_row("ADD", ADD, 1'b0, 3'd1, 1'b0);
    add_row("SUB", SUB, 1'b0, 3'd1, 1'b0);
    add_row("INC", INC, 1'b0, 3'd1, 1'b0);
    add_row("LOAD", LOAD, 1'b0, 3'd5, 1'b0);
    add_row("STORE", STORE, 1'b0, 3'd2, 1'b0);
    add_row("LOAD_REG", LOAD_REG, 1'b0, 3'd3, 1'b0);
    add_row("JUMP", JUMP, 1'b0, 3'd2, 1'b0);
    add_row("JUMPZ_TAKEN", JUMPZ, 1'b1, 3'd3, 1'b0);
    add_row("JUMPZ_SKIP", JUMPZ, 1'b0, 3'd2, 1'b0);
    add_row("MVAC_TOTAL", MVAC_TOTAL, 1'b0, 3'd1, 1'b0);
    add_row("MVAC_ALPHAP", MVAC_ALPHAP, 1'b0, 3'd1, 1'b0);
    add_row("MVAC_BETAP", MVAC_BETAP, 1'b0, 3'd1, 1'b0);
    add_row("MVAC_GAMMAP", MVAC_GAMMAP, 1'b0, 3'd1, 1'b0);
    add_row("MVAC_R", MVAC_R, 1'b0, 3'd1, 1'b0);
    add_row("MVAC_ROW", MVAC_ROW, 1'b0, 3'd1, 1'b0);
    add_row("MVAC_CAT", MVAC_CAT, 1'b0, 3'd1, 1'b0);
    add_row("MVAC_CB", MVAC_CB, 1'b0, 3'd1, 1'b0);
    add_row("MVAC_RNOW", MVAC_RNOW, 1'b0, 3'd1, 1'b0);
    add_row("MVAC_CATNOW", MVAC_CATNOW, 1'b0, 3'd1, 1'b0);
    add_row("MVAC_CBNOW", MVAC_CBNOW, 1'b0, 3'd1, 1'b0);
    add_row("MOV_TOTAL", MOV_TOTAL, 1'b0, 3'd1, 1'b0);
    add_row("MOV_ALPHAP", MOV_ALPHAP, 1'b0, 3'd1, 1'b0);
    add_row("MOV_BETAP", MOV_BETAP, 1'b0, 3'd1, 1'b0);
    add_row("MOV_GAMMAP", MOV_GAMMAP, 1'b0, 3'd1, 1'b0);
    add_row("MOV_R", MOV_R, 1'b0, 3'd1, 1'b0);
    add_row("MOV_ROW", MOV_ROW, 1'b0, 3'd1, 1'b0);
    add_row("MOV_CAT", MOV_CAT, 1'b0, 3'd1, 1'b0);
    add_row("MOV_CB", MOV_CB, 1'b0, 3'd1, 1'b0);
    add_row("MOV_RNOW", MOV_RNOW, 1'b0, 3'd1, 1'b0);
    add_row("MOV_CATNOW", MOV_CATNOW, 1'b0, 3'd1, 1'b0);
    add_row("MOV_CBNOW", MOV_CBNOW, 1'b0, 3'd1, 1'b0);
    add_row("ENDOP", ENDOP, 1'b0, 3'd1, 1'b1);
    add_row("CLR_RESTART", CLR, 1'b0, 3'd1, 1'b0);
    add_row("BAD_OPCODE_40", 12'd40, 1'b0, 3'd0, 1'b1);   // Straight from FETCH4 to IDLE
    add_row("INC_RESTART", INC, 1'b0, 3'd1, 1'b0);
endtask

function automatic ctrl_word_t make_word(input reg_mask_t wr, input reg_mask_t rd,
                                         input mem_sel_e mem, input logic mw,
                                         input alu_op_e alu, input logic pc);
    ctrl_word_t w;
    w.write_en  = wr;
    w.read_en   = rd;
    w.mem_read  = mem;
    w.mem_write = mw;
    w.alu_op    = alu;
    w.pc_inc    = pc;
    return w;
endfunction

// Both move groups list TOTAL, ALPHAP, BETAP, GAMMAP, R, ROW, CAT, CB, RNOW, CATNOW, CBNOW
function automatic reg_mask_t move_mask(input logic [`CU_IR_WIDTH-1:0] op);
    int        idx;
    int        pos;
    reg_mask_t m;
    idx = (op - MVAC_TOTAL) % 11;
    if (idx == 0)
        pos = 14;          // TOTAL
    else if (idx < 4)
        pos = idx + 10;    // ALPHAP, BETAP and GAMMAP sit at bits 11 to 13
    else
        pos = idx;         // R through CBNOW sit at bits 4 to 10
    m = 1;
    return m << pos;
endfunction

function automatic ctrl_word_t fetch_word(input int step);
    case (step)
        0:       return make_word(REG_AR, REG_PC, MEM_NONE, 1'b0, ALU_IDLE, 1'b0);
        1:       return make_word(REG_DR, REG_NONE, MEM_INSTR, 1'b0, ALU_IDLE, 1'b1);
        2:       return make_word(REG_IR | REG_AR, REG_DR | REG_PC, MEM_NONE, 1'b0,
                                  ALU_IDLE, 1'b0);
        default: return CTRL_INACTIVE;   // FETCH4 only waits for the decode
    endcase
endfunction

function automatic ctrl_word_t exec_word(input logic [`CU_IR_WIDTH-1:0] op, input logic z,
                                         input int step);
    logic [2:0] s;
    ctrl_word_t w;
    s = step[2:0];
    w = CTRL_INACTIVE;   // ENDOP1 drives nothing
    if (op >= MVAC_TOTAL && op <= MVAC_CBNOW)
        w = make_word(move_mask(op), REG_AC, MEM_NONE, 1'b0, ALU_IDLE, 1'b0);
    else if (op >= MOV_TOTAL && op <= MOV_CBNOW)
        w = make_word(REG_AC, move_mask(op), MEM_NONE, 1'b0, ALU_PASS, 1'b0);
    else if (op == JUMPZ && !z)
        // Skip path steps over the target word, then refetches from PC
        w = (s == 0) ? make_word(REG_NONE, REG_NONE, MEM_NONE, 1'b0, ALU_IDLE, 1'b1)
                     : make_word(REG_AR, REG_PC, MEM_NONE, 1'b0, ALU_IDLE, 1'b0);
    else
    begin
        case ({op, s})
            {CLR, 3'd0}:      w = make_word(REG_AC, REG_NONE, MEM_NONE, 1'b0, ALU_ZERO, 1'b0);
            {LOAD, 3'd0}:     w = make_word(REG_DR, REG_NONE, MEM_INSTR, 1'b0, ALU_IDLE, 1'b0);
            {LOAD, 3'd1}:     w = make_word(REG_AR, REG_DR, MEM_NONE, 1'b0, ALU_IDLE, 1'b0);
            {LOAD, 3'd2}:     w = make_word(REG_NONE, REG_NONE, MEM_NONE, 1'b0, ALU_IDLE, 1'b1);
            {LOAD, 3'd3}:     w = make_word(REG_DR, REG_NONE, MEM_DATA, 1'b0, ALU_IDLE, 1'b0);
            {LOAD, 3'd4}:     w = make_word(REG_AC, REG_DR, MEM_NONE, 1'b0, ALU_PASS, 1'b0);
            {MUL, 3'd0}:      w = make_word(REG_AC, REG_R, MEM_NONE, 1'b0, ALU_MUL, 1'b0);
            {ADD, 3'd0}:      w = make_word(REG_AC, REG_R, MEM_NONE, 1'b0, ALU_ADD, 1'b0);
            {SUB, 3'd0}:      w = make_word(REG_AC, REG_R, MEM_NONE, 1'b0, ALU_SUB, 1'b0);
            {INC, 3'd0}:      w = make_word(REG_AC, REG_NONE, MEM_NONE, 1'b0, ALU_INC, 1'b0);
            {JUMP, 3'd0}, {JUMPZ, 3'd0}:
                w = make_word(REG_DR, REG_NONE, MEM_INSTR, 1'b0, ALU_IDLE, 1'b1);
            {JUMP, 3'd1}, {JUMPZ, 3'd1}:
                w = make_word(REG_PC, REG_DR, MEM_NONE, 1'b0, ALU_IDLE, 1'b0);
            {JUMPZ, 3'd2}:    w = make_word(REG_AR, REG_PC, MEM_NONE, 1'b0, ALU_IDLE, 1'b0);
            {STORE, 3'd0}:    w = make_word(REG_AR, REG_GAMMAP, MEM_NONE, 1'b0, ALU_IDLE, 1'b0);
            {STORE, 3'd1}:    w = make_word(REG_DR, REG_AC, MEM_NONE, 1'b1, ALU_IDLE, 1'b0);
            {LOAD_REG, 3'd0}: w = make_word(REG_AR, REG_AC, MEM_DATA, 1'b0, ALU_IDLE, 1'b0);
            {LOAD_REG, 3'd1}: w = make_word(REG_DR, REG_NONE, MEM_DATA, 1'b0, ALU_IDLE, 1'b0);
            {LOAD_REG, 3'd2}: w = make_word(REG_AC, REG_DR, MEM_NONE, 1'b0, ALU_PASS, 1'b0);
            default:          w = CTRL_INACTIVE;
        endcase
    end
    return w;
endfunction

`endif

//--- sim/control_unit_tb.sv
/*
 * Testbench for the control unit that runs every table row through fetch
 * and execute and checks the control word in each cycle
 */
`timescale 1ns/1ps
`default_nettype none

`include "cu_cfg.svh"

module control_unit_tb import cu_pkg::*;
();

    localparam int WAIT_LIMIT = 20;   // Cycles allowed to reach IDLE or FETCH1

    logic                    clk;
    logic                    reset;
    logic                    start;
    logic                    zflag;
    logic [`CU_IR_WIDTH-1:0] opcode;
    ctrl_word_t              ctrl;

    `include "cu_test_table.svh"

    control_unit i_control_unit (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .zflag  (zflag),
        .opcode (opcode),
        .ctrl   (ctrl)
    );

    always #20 clk = ~clk;

    task automatic check_ctrl(input logic [8*16-1:0] name, input ctrl_word_t exp,
                              input ctrl_word_t act);
        if (act !== exp)
        begin
            $display("MISMATCH %0s: expected ctrl %h, actual %h", name, exp, act);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic check_alu(input logic [8*16-1:0] name, input alu_op_e exp,
                             input alu_op_e act);
        if (act !== exp)
        begin
            $display("MISMATCH %0s: expected alu_op %0d, actual %0d", name, exp, act);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    // Checks mid cycle, then moves on to just after the next rising edge
    task automatic check_cycle(input logic [8*16-1:0] name, input ctrl_word_t exp);
        @(negedge clk);
        check_alu(name, exp.alu_op, ctrl.alu_op);
        check_ctrl(name, exp, ctrl);
        @(posedge clk);
        #2;
    endtask

    task automatic wait_for_state(input logic [8*16-1:0] name, input cu_state_e target,
                                  input string what);
        int count;
        count = 0;
        while (i_control_unit.state !== target)
        begin
            check_cycle(name, CTRL_INACTIVE);   // Only IDLE or ENDOP1 may pass here
            start = 1'b0;
            count++;
            if (count >= WAIT_LIMIT)
            begin
                $display("ERROR %0s: the unit never reached %0s within %0d cycles",
                         name, what, WAIT_LIMIT);
                $display("Finished with errors");
                $fatal(1);
            end
        end
        start = 1'b0;
    endtask

    initial
    begin
        test_row_t row;
        logic      dut_idle;
        int        i;
        int        k;

        clk    = 1'b0;
        reset  = 1'b1;
        start  = 1'b0;
        zflag  = 1'b0;
        opcode = '0;
        build_table();

        @(posedge clk);
        #2;
        for (i = 0; i < 16; i++)
        begin
            if (i == 15)
                reset = 1'b0;   // Sixteen edges have seen reset by now
            check_cycle("RESET", CTRL_INACTIVE);
        end

        dut_idle = 1'b1;
        for (i = 0; i < test_table.size(); i++)
        begin
            row    = test_table[i];
            opcode = row.opcode;   // Held through fetch
            zflag  = row.zflag;
            if (dut_idle)
            begin
                // IDLE must stay quiet until start arrives
                check_cycle(row.name, CTRL_INACTIVE);
                check_cycle(row.name, CTRL_INACTIVE);
                start = 1'b1;
                wait_for_state(row.name, FETCH1, "FETCH1");
            end
            for (k = 0; k < 4; k++)
                check_cycle(row.name, fetch_word(k));
            // The execute phase has to run from what was latched as FETCH4 ended
            opcode = ~row.opcode;
            zflag  = ~row.zflag;
            for (k = 0; k < row.exec_cycles; k++)
                check_cycle(row.name, exec_word(row.opcode, row.zflag, k));
            if (row.next_idle)
                wait_for_state(row.name, IDLE, "IDLE");
            dut_idle = row.next_idle;
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+rtl
+incdir+sim
rtl/cu_pkg.sv
rtl/opcode_decoder.sv
rtl/instr_sequencer.sv
rtl/control_word_gen.sv
rtl/control_unit.sv
sim/control_unit_tb.sv
